/* build.f */
+incdir+include
verilog/sd_pkg.sv
verilog/sd_cmd_tx.sv
verilog/sd_resp_rx.sv
verilog/sd_init_seq.sv
verilog/sd_read_seq.sv
verilog/sd_block_buffer.sv
verilog/sd_card_top.sv
tb/sd_card_model.sv
tb/sd_card_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and decide by the log
verilator --binary --timing --timescale 1ns/10ps -f build.f --top-module sd_card_tb -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo 'build or simulation failed'; exit 1; }
cat sim.log
grep -q 'All tests passed!' sim.log && echo 'PASS' || { echo 'FAIL'; exit 1; }

/* tb/sd_card_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_card_tb
	import sd_pkg::*;
();

	localparam int clk_period = 4;
	localparam int scenario_count = 4;
	localparam int scenario_clks = 12000; // power-up, init, one block, sweep

	logic sdclk = 1'b0;
	logic reset;
	logic dout;
	word_sel_t word_sel;
	logic cs;
	logic din;
	data_word_t led;
	logic init_ok;
	logic init_err;
	logic read_end;
	logic read_err;

	int idle_polls;
	logic bad_cmd0;
	logic bad_cmd8;
	logic bad_cmd17;
	logic frame_stb;
	logic [47:0] frame_seen;
	logic byte_stb;
	logic [7:0] byte_sent;

	logic [47:0] frames [$];
	logic [7:0] block [$];
	logic init_at_cmd17;
	logic sweep_on;
	int errors;

	always #(clk_period / 2) sdclk = ~sdclk;

	sd_card_top u_sd_card_top (
		.sdclk(sdclk), .reset(reset), .dout(dout), .word_sel(word_sel),
		.cs(cs), .din(din), .led(led), .init_ok(init_ok), .init_err(init_err),
		.read_end(read_end), .read_err(read_err)
	);

	sd_card_model u_card_model (
		.sdclk(sdclk), .cs(cs), .din(din), .idle_polls(idle_polls),
		.bad_cmd0(bad_cmd0), .bad_cmd8(bad_cmd8), .bad_cmd17(bad_cmd17),
		.dout(dout), .frame_stb(frame_stb), .frame_seen(frame_seen),
		.byte_stb(byte_stb), .byte_sent(byte_sent)
	);

	always @(posedge frame_stb) begin
		frames.push_back(frame_seen);
		if (frame_seen[45:40] == 6'd17) begin
			init_at_cmd17 = init_ok;
		end
	end

	always @(posedge byte_stb) begin
		block.push_back(byte_sent);
	end

	// word k has byte 2k high and byte 2k+1 low
	function automatic data_word_t ref_word(input word_sel_t ws);
		int idx;
		idx = 2 * int'(ws);
		return {block[idx], block[idx + 1]};
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
			errors++;
		end
	endtask

	always @(negedge sdclk) begin
		if (sweep_on) begin
			check_value(64'(led), 64'(ref_word(word_sel)), $sformatf("led, word %0d", word_sel));
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(posedge sdclk);
		#1;
		frames.delete();
		block.delete();
		init_at_cmd17 = 1'b0;
		reset = 1'b0;
	endtask

	task automatic check_power_up();
		check_value(64'({init_ok, init_err, read_end, read_err}), 64'(0), "status after reset");
		repeat (power_up_clks) begin
			check_value(64'({cs, din}), 64'(2'b11), "cs and din during power-up");
			@(posedge sdclk);
			#1;
		end
		check_value(64'(cs), 64'(0), "cs after power-up");
	endtask

	task automatic check_frame_log(input int polls, input int stage);
		logic [47:0] exp_frames [$];
		exp_frames.push_back(cmd0_frame);
		if (stage > 0) begin
			exp_frames.push_back(cmd8_frame);
		end
		if (stage > 1) begin
			repeat (polls + 1) begin
				exp_frames.push_back(cmd55_frame);
				exp_frames.push_back(acmd41_frame);
			end
			exp_frames.push_back({cmd17_head, 32'd0, cmd17_tail}); // block 0
		end
		check_value(64'(frames.size()), 64'(exp_frames.size()), "frame count");
		foreach (exp_frames[i]) begin
			if (i < frames.size()) begin
				check_value(64'(frames[i]), 64'(exp_frames[i]), $sformatf("frame %0d", i));
			end
		end
	endtask

	task automatic sweep_words();
		check_value(64'(block.size()), 64'(block_bytes), "bytes sent by the card");
		if (block.size() == block_bytes) begin
			for (int ws = 0; ws < 256; ws++) begin
				@(posedge sdclk);
				#1;
				word_sel = word_sel_t'(ws);
				sweep_on = 1'b1;
			end
			@(posedge sdclk);
			#1;
			sweep_on = 1'b0;
		end
	endtask

	task automatic run_scenario(input int polls, input logic b0, input logic b8, input logic b17);
		int stage;
		stage = b0 ? 0 : (b8 ? 1 : 2); // last command that goes out
		@(posedge sdclk);
		#1;
		idle_polls = polls;
		bad_cmd0 = b0;
		bad_cmd8 = b8;
		bad_cmd17 = b17;
		apply_reset();
		check_power_up();
		while (!(init_err || read_end || read_err)) begin
			@(posedge sdclk);
			#1;
		end
		repeat (64) @(posedge sdclk);
		#1;
		check_frame_log(polls, stage);
		check_value(64'(init_ok), 64'(stage == 2), "init_ok");
		check_value(64'(init_err), 64'(stage < 2), "init_err");
		check_value(64'(read_end), 64'(stage == 2 && !b17), "read_end");
		check_value(64'(read_err), 64'(stage == 2 && b17), "read_err");
		if (stage < 2) begin
			check_value(64'(cs), 64'(1), "cs after init error");
		end else begin
			check_value(64'(init_at_cmd17), 64'(1), "init_ok when cmd17 went out");
		end
		if (stage == 2 && !b17) begin
			sweep_words();
		end
	endtask

	initial begin
		reset = 1'b1;
		word_sel = '0;
		idle_polls = 0;
		bad_cmd0 = 1'b0;
		bad_cmd8 = 1'b0;
		bad_cmd17 = 1'b0;
		init_at_cmd17 = 1'b0;
		sweep_on = 1'b0;
		errors = 0;
		run_scenario(3, 1'b0, 1'b0, 1'b0); // good run
		run_scenario(0, 1'b1, 1'b0, 1'b0);
		run_scenario(1, 1'b0, 1'b1, 1'b0);
		run_scenario(0, 1'b0, 1'b0, 1'b1);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(scenario_count * scenario_clks * clk_period);
		$display("timeout: run still busy after %0d clocks", scenario_count * scenario_clks);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/sd_card_model.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_card_model
	import sd_pkg::*;
(
	input logic sdclk,
	input logic cs,
	input logic din,
	input int idle_polls, // acmd41 replies that keep the card idle
	input logic bad_cmd0,
	input logic bad_cmd8,
	input logic bad_cmd17,
	output logic dout,
	output logic frame_stb,
	output logic [47:0] frame_seen,
	output logic byte_stb,
	output logic [7:0] byte_sent
);

	integer seed;
	int polls;
	logic [47:0] frame;

	task automatic get_frame(output logic [47:0] f);
		f = '1;
		do begin
			@(negedge sdclk);
		end while (cs || din); // start bit
		f = {f[46:0], din};
		repeat (frame_bits - 1) begin
			@(negedge sdclk);
			f = {f[46:0], din};
		end
	endtask

	// mark flags a data byte for the block log
	task automatic send_byte(input logic [7:0] b, input logic mark);
		for (int i = 7; i >= 0; i--) begin
			@(posedge sdclk);
			#1;
			dout = b[i];
			byte_sent = mark ? b : byte_sent;
			byte_stb = mark && i == 7;
		end
	endtask

	task automatic idle_bits(input int n);
		repeat (n) begin
			@(posedge sdclk);
			#1;
			dout = 1'b1;
			byte_stb = 1'b0;
		end
	endtask

	initial begin
		seed = 49781;
		polls = 0;
		dout = 1'b1;
		frame_stb = 1'b0;
		frame_seen = '0;
		byte_stb = 1'b0;
		byte_sent = '0;
		forever begin
			get_frame(frame);
			frame_seen = frame;
			frame_stb = 1'b1;
			idle_bits(16); // ncr, two bytes of ones
			frame_stb = 1'b0;
			case (frame[45:40])
				6'd0: begin
					polls = 0;
					send_byte(bad_cmd0 ? 8'h05 : r1_idle, 1'b0);
				end
				6'd8: begin
					send_byte(r1_idle, 1'b0);
					send_byte(8'h00, 1'b0);
					send_byte(8'h00, 1'b0);
					send_byte(8'h01, 1'b0); // voltage accepted
					send_byte(bad_cmd8 ? 8'h55 : 8'hAA, 1'b0);
				end
				6'd55: send_byte(polls < idle_polls ? r1_idle : r1_ready, 1'b0);
				6'd41: begin
					if (polls < idle_polls) begin
						polls++;
						send_byte(r1_idle, 1'b0); // still busy
					end else begin
						send_byte(r1_ready, 1'b0);
					end
				end
				6'd17: begin
					if (bad_cmd17) begin
						send_byte(8'h40, 1'b0); // parameter error
					end else begin
						send_byte(r1_ready, 1'b0);
						idle_bits(16);
						send_byte(data_token, 1'b0);
						repeat (block_bytes) send_byte(8'($random(seed)), 1'b1);
						send_byte(8'h3C, 1'b0);
						send_byte(8'hA5, 1'b0);
					end
				end
				default: send_byte(8'h04, 1'b0); // illegal command
			endcase
			idle_bits(1);
		end
	end

endmodule

`default_nettype wire

/* verilog/sd_card_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_card_top
	import sd_pkg::*;
(
	input logic sdclk,
	input logic reset,
	input logic dout,
	input word_sel_t word_sel,
	output logic cs,
	output logic din,
	output data_word_t led,
	output logic init_ok,
	output logic init_err,
	output logic read_end,
	output logic read_err
);

	eng_ctrl_t init_ctrl;
	eng_ctrl_t read_ctrl;
	eng_ctrl_t eng_ctrl;
	sd_bus_t init_bus;
	sd_bus_t read_bus;
	sd_bus_t pin_bus;
	logic tx_din;
	logic tx_done;
	resp_t resp;
	logic resp_valid;
	logic wr_en;
	byte_addr_t wr_addr;
	logic [7:0] wr_byte;

	// read side owns the engine and pins once init is done
	assign eng_ctrl = init_ok ? read_ctrl : init_ctrl;
	assign pin_bus = init_ok ? read_bus : init_bus;
	assign cs = pin_bus.cs;
	assign din = pin_bus.din | tx_din;

	sd_init_seq u_init_seq (
		.sdclk(sdclk),
		.reset(reset),
		.tx_done(tx_done),
		.resp_valid(resp_valid),
		.resp(resp),
		.ctrl(init_ctrl),
		.bus(init_bus),
		.init_ok(init_ok),
		.init_err(init_err)
	);

	sd_read_seq u_read_seq (
		.sdclk(sdclk),
		.reset(reset),
		.start(init_ok),
		.tx_done(tx_done),
		.resp_valid(resp_valid),
		.resp(resp),
		.dout(dout),
		.ctrl(read_ctrl),
		.bus(read_bus),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_byte(wr_byte),
		.read_end(read_end),
		.read_err(read_err)
	);

	sd_cmd_tx u_cmd_tx (
		.sdclk(sdclk),
		.reset(reset),
		.ctrl(eng_ctrl),
		.din(tx_din),
		.tx_done(tx_done)
	);

	sd_resp_rx u_resp_rx (
		.sdclk(sdclk),
		.reset(reset),
		.ctrl(eng_ctrl),
		.dout(dout),
		.resp(resp),
		.resp_valid(resp_valid)
	);

	sd_block_buffer u_block_buffer (
		.sdclk(sdclk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_byte(wr_byte),
		.word_sel(word_sel),
		.rd_word(led)
	);

endmodule

`default_nettype wire

/* verilog/sd_block_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_block_buffer
	import sd_pkg::*;
(
	input logic sdclk,
	input logic wr_en,
	input byte_addr_t wr_addr,
	input logic [7:0] wr_byte,
	input word_sel_t word_sel,
	output data_word_t rd_word
);

	logic [7:0] mem [block_bytes];

	always_ff @(posedge sdclk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_byte;
		end
	end

	// even byte arrived first, so it is the high half
	assign rd_word = {mem[{word_sel, 1'b0}], mem[{word_sel, 1'b1}]};

endmodule

`default_nettype wire

/* verilog/sd_read_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_read_seq
	import sd_pkg::*;
(
	input logic sdclk,
	input logic reset,
	input logic start,
	input logic tx_done,
	input logic resp_valid,
	input resp_t resp,
	input logic dout,
	output eng_ctrl_t ctrl,
	output sd_bus_t bus,
	output logic wr_en,
	output byte_addr_t wr_addr,
	output logic [7:0] wr_byte,
	output logic read_end,
	output logic read_err
);

	read_state_t state;
	read_state_t next_state;
	logic [7:0] win;
	logic [7:0] win_next;
	logic [2:0] bit_cnt;
	byte_addr_t cnt; // byte index, then tail clocks
	logic byte_last;
	logic block_last;
	logic tail_last;
	r1_t r1;

	assign r1 = resp[7:0];
	assign win_next = {win[6:0], dout};
	assign byte_last = bit_cnt == 3'd7;
	assign block_last = cnt == byte_addr_t'(block_bytes - 1);
	assign tail_last = cnt == byte_addr_t'(crc_bits + gap_clks - 1);

	always_comb begin
		ctrl = '0;
		ctrl.frame = {cmd17_head, read_block_addr, cmd17_tail};
		ctrl.cmd_load = state == rd_load;
		ctrl.tx_en = state == rd_send;
		ctrl.rx_en = state == rd_rcv;
		bus.cs = state == rd_idle || state == rd_stop;
		bus.din = ~ctrl.tx_en;
	end

	always_comb begin
		next_state = state;
		case (state)
			rd_idle: next_state = start ? rd_load : state;
			rd_load: next_state = rd_send;
			rd_send: next_state = tx_done ? rd_rcv : state;
			rd_rcv: begin
				if (resp_valid) begin
					next_state = (r1 == r1_ready) ? rd_token : rd_stop;
				end
			end
			rd_token: next_state = (win_next == data_token) ? rd_data : state;
			rd_data: next_state = (byte_last && block_last) ? rd_tail : state;
			rd_tail: next_state = tail_last ? rd_stop : state; // crc and gap unchecked
			default: next_state = state;
		endcase
	end

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			state <= rd_idle;
			win <= '1;
			bit_cnt <= '0;
			cnt <= '0;
			wr_en <= 1'b0;
			read_end <= 1'b0;
			read_err <= 1'b0;
		end else begin
			state <= next_state;
			wr_en <= 1'b0;
			win <= (state == rd_token || state == rd_data) ? win_next : '1;
			bit_cnt <= (state == rd_data) ? bit_cnt + 3'd1 : '0;
			if (state == rd_data && byte_last) begin
				wr_en <= 1'b1;
				cnt <= block_last ? '0 : cnt + byte_addr_t'(1);
			end else if (state == rd_tail) begin
				cnt <= cnt + byte_addr_t'(1);
			end
			if (state == rd_rcv && resp_valid && r1 != r1_ready) begin
				read_err <= 1'b1;
			end
			if (state == rd_tail && tail_last) begin
				read_end <= 1'b1;
			end
		end
	end

	// byte completes on its eighth bit
	always_ff @(posedge sdclk) begin
		if (state == rd_data && byte_last) begin
			wr_addr <= cnt;
			wr_byte <= win_next;
		end
	end

endmodule

`default_nettype wire

/* verilog/sd_init_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_init_seq
	import sd_pkg::*;
(
	input logic sdclk,
	input logic reset,
	input logic tx_done,
	input logic resp_valid,
	input resp_t resp,
	output eng_ctrl_t ctrl,
	output sd_bus_t bus,
	output logic init_ok,
	output logic init_err
);

	init_state_t state;
	init_state_t next_state;
	wait_cnt_t wait_cnt; // power-up and gap clocks share it
	logic waiting;
	logic gap_done;
	logic echo_ok;
	r1_t r1;

	assign r1 = resp[7:0];
	assign gap_done = wait_cnt == wait_cnt_t'(gap_clks - 1);
	assign echo_ok = resp[39:32] == r7_check[15:8] && resp[7:0] == r7_check[7:0];
	assign init_ok = state == st_success;
	assign init_err = state == st_error;

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			state <= st_await;
			wait_cnt <= '0;
		end else begin
			state <= next_state;
			wait_cnt <= waiting ? wait_cnt + wait_cnt_t'(1) : '0;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			st_await: begin
				if (wait_cnt == wait_cnt_t'(power_up_clks - 1)) begin
					next_state = st_cmd0_load;
				end
			end
			st_cmd0_load: next_state = st_cmd0_send;
			st_cmd0_send: next_state = tx_done ? st_cmd0_rcv : state;
			st_cmd0_rcv: begin
				if (resp_valid) begin
					next_state = (r1 == r1_idle) ? st_cmd0_gap : st_error;
				end
			end
			st_cmd0_gap: next_state = gap_done ? st_cmd8_load : state;
			st_cmd8_load: next_state = st_cmd8_send;
			st_cmd8_send: next_state = tx_done ? st_cmd8_rcv : state;
			st_cmd8_rcv: begin
				if (resp_valid) begin
					next_state = echo_ok ? st_cmd8_gap : st_error;
				end
			end
			st_cmd8_gap: next_state = gap_done ? st_cmd55_load : state;
			st_cmd55_load: next_state = st_cmd55_send;
			st_cmd55_send: next_state = tx_done ? st_cmd55_rcv : state;
			st_cmd55_rcv: begin
				if (resp_valid) begin
					next_state = (r1 == r1_idle || r1 == r1_ready) ? st_cmd55_gap : st_error;
				end
			end
			st_cmd55_gap: next_state = gap_done ? st_acmd41_load : state;
			st_acmd41_load: next_state = st_acmd41_send;
			st_acmd41_send: next_state = tx_done ? st_acmd41_rcv : state;
			st_acmd41_rcv: begin
				if (resp_valid) begin
					if (r1 == r1_idle) begin
						next_state = st_acmd41_retry; // card still busy
					end else if (r1 == r1_ready) begin
						next_state = st_acmd41_gap;
					end else begin
						next_state = st_error;
					end
				end
			end
			st_acmd41_retry: next_state = gap_done ? st_cmd55_load : state;
			st_acmd41_gap: next_state = gap_done ? st_success : state;
			default: next_state = state; // success and error hold
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.frame = '1;
		bus.cs = 1'b0;
		waiting = 1'b0;
		case (state)
			st_await: begin
				bus.cs = 1'b1;
				waiting = 1'b1;
			end
			st_cmd0_load: begin
				ctrl.cmd_load = 1'b1;
				ctrl.frame = cmd0_frame;
			end
			st_cmd8_load: begin
				ctrl.cmd_load = 1'b1;
				ctrl.frame = cmd8_frame;
			end
			st_cmd55_load: begin
				ctrl.cmd_load = 1'b1;
				ctrl.frame = cmd55_frame;
			end
			st_acmd41_load: begin
				ctrl.cmd_load = 1'b1;
				ctrl.frame = acmd41_frame;
			end
			st_cmd0_send, st_cmd8_send, st_cmd55_send, st_acmd41_send: ctrl.tx_en = 1'b1;
			st_cmd0_rcv, st_cmd55_rcv, st_acmd41_rcv: ctrl.rx_en = 1'b1;
			st_cmd8_rcv: begin
				ctrl.rx_en = 1'b1;
				ctrl.rx_long = 1'b1; // r7
			end
			st_cmd0_gap, st_cmd8_gap, st_cmd55_gap, st_acmd41_retry, st_acmd41_gap: begin
				waiting = 1'b1;
			end
			default: bus.cs = 1'b1;
		endcase
		bus.din = ~ctrl.tx_en; // held high unless a frame goes out
	end

endmodule

`default_nettype wire

/* verilog/sd_resp_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_resp_rx
	import sd_pkg::*;
(
	input logic sdclk,
	input logic reset,
	input eng_ctrl_t ctrl,
	input logic dout,
	output resp_t resp,
	output logic resp_valid
);

	localparam int resp_bits = $bits(resp_t);

	resp_t shift_q;
	logic held;
	logic start_seen;

	// the card's first zero is the r1 msb, it lands at bit 7 or bit 39
	assign start_seen = ctrl.rx_long ? ~shift_q[resp_bits-1] : ~shift_q[7];
	assign resp = shift_q;
	assign resp_valid = ctrl.rx_en & start_seen & ~held;

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			shift_q <= '1;
			held <= 1'b0;
		end else if (!ctrl.rx_en) begin
			shift_q <= '1;
			held <= 1'b0;
		end else begin
			if (!start_seen) begin
				shift_q <= {shift_q[resp_bits-2:0], dout};
			end
			held <= start_seen; // valid only on the first cycle
		end
	end

endmodule

`default_nettype wire

/* verilog/sd_cmd_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module sd_cmd_tx
	import sd_pkg::*;
(
	input logic sdclk,
	input logic reset,
	input eng_ctrl_t ctrl,
	output logic din,
	output logic tx_done
);

	cmd_frame_t frame_q;
	logic [5:0] bit_cnt; // runs one past frame_bits, then holds

	always_ff @(posedge sdclk) begin
		if (ctrl.cmd_load) begin
			frame_q <= ctrl.frame;
		end else if (ctrl.tx_en && bit_cnt < 6'(frame_bits)) begin
			frame_q <= {frame_q[frame_bits-2:0], 1'b1};
		end
	end

	always_ff @(posedge sdclk or posedge reset) begin
		if (reset) begin
			bit_cnt <= '0;
			din <= 1'b1;
			tx_done <= 1'b0;
		end else begin
			din <= 1'b1; // line idles high
			tx_done <= 1'b0;
			if (ctrl.cmd_load) begin
				bit_cnt <= '0;
			end else if (ctrl.tx_en) begin
				if (bit_cnt < 6'(frame_bits)) begin
					din <= frame_q[frame_bits-1]; // msb first
				end
				if (bit_cnt <= 6'(frame_bits)) begin
					bit_cnt <= bit_cnt + 6'd1;
				end
				tx_done <= bit_cnt == 6'(frame_bits);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/sd_pkg.sv */
`default_nettype none

package sd_pkg;

	`include "sd_frames.svh"

	localparam int power_up_clks = 512;
	localparam int gap_clks = 16; // idle clocks after each exchange
	localparam int block_bytes = 512;
	localparam int frame_bits = 48;
	localparam int crc_bits = 16; // data crc after the block
	localparam logic [31:0] read_block_addr = 32'd0;
	localparam logic [7:0] data_token = 8'hFE;

	typedef logic [frame_bits-1:0] cmd_frame_t;
	typedef logic [39:0] resp_t; // r7 is 40 bits, r1 sits in the low byte
	typedef logic [7:0] r1_t;
	typedef logic [7:0] word_sel_t;
	typedef logic [15:0] data_word_t;
	typedef logic [$clog2(block_bytes)-1:0] byte_addr_t;
	typedef logic [$clog2(power_up_clks)-1:0] wait_cnt_t;

	localparam r1_t r1_idle = 8'h01;
	localparam r1_t r1_ready = 8'h00;
	localparam logic [15:0] r7_check = 16'h01_AA; // echo head and tail

	typedef struct packed {
		logic cs;
		logic din;
	} sd_bus_t;

	typedef struct packed {
		logic cmd_load;
		logic tx_en;
		logic rx_en;
		logic rx_long; // r7 instead of r1
		cmd_frame_t frame;
	} eng_ctrl_t;

	typedef enum logic [4:0] {
		st_await,
		st_cmd0_load, st_cmd0_send, st_cmd0_rcv, st_cmd0_gap,
		st_cmd8_load, st_cmd8_send, st_cmd8_rcv, st_cmd8_gap,
		st_cmd55_load, st_cmd55_send, st_cmd55_rcv, st_cmd55_gap,
		st_acmd41_load, st_acmd41_send, st_acmd41_rcv,
		st_acmd41_retry, st_acmd41_gap,
		st_success, st_error
	} init_state_t;

	typedef enum logic [2:0] {
		rd_idle, rd_load, rd_send, rd_rcv, rd_token, rd_data, rd_tail, rd_stop
	} read_state_t;

endpackage

`default_nettype wire

/* include/sd_frames.svh */
`ifndef sd_frames_svh
`define sd_frames_svh

// spi-mode command frames: start bits, index, argument, crc7 and end bit
localparam logic [47:0] cmd0_frame   = 48'h40_00_00_00_00_95; // go idle
localparam logic [47:0] cmd8_frame   = 48'h48_00_00_01_AA_87; // 2.7-3.6 V, pattern AA
localparam logic [47:0] cmd55_frame  = 48'h77_00_00_00_00_65; // app command prefix
localparam logic [47:0] acmd41_frame = 48'h69_40_00_00_00_77; // hcs set

// cmd17 wraps a 32-bit block address
localparam logic [7:0] cmd17_head = 8'h51;
localparam logic [7:0] cmd17_tail = 8'hFF; // crc unchecked in spi mode

`endif
